// ==== csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  cause_t;

    typedef enum logic [1:0] {
        csr_op_rw = 2'b01,
        csr_op_rs = 2'b10,
        csr_op_rc = 2'b11
    } csr_op_t;

    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_m = 2'b11
    } priv_t;

    typedef enum logic [3:0] {
        idx_mvendorid,
        idx_marchid,
        idx_mimpid,
        idx_mhartid,
        idx_mstatus,
        idx_misa,
        idx_mie,
        idx_mtvec,
        idx_mscratch,
        idx_mepc,
        idx_mcause,
        idx_mtval,
        idx_mip,
        idx_none
    } csr_idx_t;

    localparam csr_addr_t addr_mstatus   = 12'h300;
    localparam csr_addr_t addr_misa      = 12'h301;
    localparam csr_addr_t addr_mie       = 12'h304;
    localparam csr_addr_t addr_mtvec     = 12'h305;
    localparam csr_addr_t addr_mscratch  = 12'h340;
    localparam csr_addr_t addr_mepc      = 12'h341;
    localparam csr_addr_t addr_mcause    = 12'h342;
    localparam csr_addr_t addr_mtval     = 12'h343;
    localparam csr_addr_t addr_mip       = 12'h344;
    localparam csr_addr_t addr_mvendorid = 12'hf11;
    localparam csr_addr_t addr_marchid   = 12'hf12;
    localparam csr_addr_t addr_mimpid    = 12'hf13;
    localparam csr_addr_t addr_mhartid   = 12'hf14;

    // rv32 with i and u
    localparam xlen_t misa_value     = 32'h4010_0100;
    localparam xlen_t vendorid_value = 32'h0000_0000;
    localparam xlen_t archid_value   = 32'h0000_0000;
    localparam xlen_t impid_value    = 32'h0000_0001;
    localparam xlen_t hartid_value   = 32'h0000_0000;

    // mie, mpie, mpp
    localparam xlen_t mstatus_mask = 32'h0000_1888;
    localparam xlen_t irq_mask     = 32'h0000_0888;
    localparam xlen_t mtvec_mask   = 32'hffff_fffd;
    localparam xlen_t epc_mask     = 32'hffff_fffc;
    localparam xlen_t cause_mask   = 32'h8000_001f;

    localparam cause_t exc_illegal = 5'd2;
    localparam cause_t exc_ecall_u = 5'd8;
    localparam cause_t exc_ecall_m = 5'd11;
    localparam cause_t irq_msi     = 5'd3;
    localparam cause_t irq_mti     = 5'd7;
    localparam cause_t irq_mei     = 5'd11;

endpackage

// ==== csr_decode.sv ====
`timescale 1ns/10ps

module csr_decode (
    input  logic               csr_en_i,
    input  csr_pkg::csr_op_t   csr_op_i,
    input  logic [4:0]         csr_rs1_i,
    input  csr_pkg::csr_addr_t csr_addr_i,
    input  csr_pkg::priv_t     mode_i,
    output csr_pkg::csr_idx_t  csr_idx_o,
    output logic               csr_wr_en_o,
    output logic               csr_illegal_o
);
    import csr_pkg::*;

    logic writes;
    logic unimpl;
    logic priv_fault;
    logic ro_fault;

    always_comb begin
        case (csr_addr_i)
            addr_mvendorid: csr_idx_o = idx_mvendorid;
            addr_marchid:   csr_idx_o = idx_marchid;
            addr_mimpid:    csr_idx_o = idx_mimpid;
            addr_mhartid:   csr_idx_o = idx_mhartid;
            addr_mstatus:   csr_idx_o = idx_mstatus;
            addr_misa:      csr_idx_o = idx_misa;
            addr_mie:       csr_idx_o = idx_mie;
            addr_mtvec:     csr_idx_o = idx_mtvec;
            addr_mscratch:  csr_idx_o = idx_mscratch;
            addr_mepc:      csr_idx_o = idx_mepc;
            addr_mcause:    csr_idx_o = idx_mcause;
            addr_mtval:     csr_idx_o = idx_mtval;
            addr_mip:       csr_idx_o = idx_mip;
            default:        csr_idx_o = idx_none;
        endcase
    end

    always_comb begin
        // set or clear with a zero source is a pure read
        writes = (csr_op_i == csr_op_rw) || (csr_rs1_i != 5'd0);
        unimpl = (csr_idx_o == idx_none);

        // bits 9:8 give the lowest mode allowed
        priv_fault = (csr_addr_i[9:8] > mode_i);

        // 11 in bits 11:10 marks a read-only csr
        ro_fault = writes && (csr_addr_i[11:10] == 2'b11);

        csr_illegal_o = csr_en_i && (unimpl || priv_fault || ro_fault);
        csr_wr_en_o = csr_en_i && writes && !csr_illegal_o;
    end

endmodule

// ==== csr_exec.sv ====
`timescale 1ns/10ps

module csr_exec (
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::csr_idx_t csr_idx_i,
    input  logic              csr_wr_en_i,
    input  csr_pkg::csr_op_t  csr_op_i,
    input  logic              csr_imm_sel_i,
    input  logic [4:0]        csr_rs1_i,
    input  csr_pkg::xlen_t    csr_src_i,
    input  logic              trap_i,
    input  logic              trap_irq_i,
    input  csr_pkg::cause_t   trap_cause_i,
    input  csr_pkg::xlen_t    trap_pc_i,
    input  csr_pkg::xlen_t    trap_tval_i,
    input  logic              mret_i,
    input  csr_pkg::xlen_t    mip_i,
    output csr_pkg::xlen_t    csr_rdata_o,
    output csr_pkg::xlen_t    mtvec_o,
    output csr_pkg::xlen_t    mepc_o,
    output csr_pkg::xlen_t    mie_o,
    output logic              mstatus_mie_o,
    output csr_pkg::priv_t    mode_o
);
    import csr_pkg::*;

    xlen_t mstatus_q;
    xlen_t mie_q;
    xlen_t mtvec_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mtval_q;
    priv_t mode_q;

    xlen_t old_val;
    xlen_t operand;
    xlen_t new_val;
    xlen_t mstatus_wr;
    logic  wr_en;

    always_comb begin
        case (csr_idx_i)
            idx_mvendorid: old_val = vendorid_value;
            idx_marchid:   old_val = archid_value;
            idx_mimpid:    old_val = impid_value;
            idx_mhartid:   old_val = hartid_value;
            idx_mstatus:   old_val = mstatus_q;
            idx_misa:      old_val = misa_value;
            idx_mie:       old_val = mie_q;
            idx_mtvec:     old_val = mtvec_q;
            idx_mscratch:  old_val = mscratch_q;
            idx_mepc:      old_val = mepc_q;
            idx_mcause:    old_val = mcause_q;
            idx_mtval:     old_val = mtval_q;
            idx_mip:       old_val = mip_i;
            default:       old_val = '0;
        endcase
    end

    assign operand = csr_imm_sel_i ? {27'b0, csr_rs1_i} : csr_src_i;

    always_comb begin
        case (csr_op_i)
            csr_op_rs: new_val = old_val | operand;
            csr_op_rc: new_val = old_val & ~operand;
            default:   new_val = operand;
        endcase
    end

    // mpp only holds m or u, anything else reads back as u
    always_comb begin
        mstatus_wr = new_val & mstatus_mask;
        mstatus_wr[12:11] = (new_val[12:11] == 2'b11) ? 2'b11 : 2'b00;
    end

    // trap and mret take the cycle, the csr write is dropped
    assign wr_en = csr_wr_en_i & ~trap_i & ~mret_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mode_q     <= priv_m;
        end else if (trap_i) begin
            mepc_q           <= trap_pc_i & epc_mask;
            mcause_q         <= {trap_irq_i, 26'b0, trap_cause_i};
            mtval_q          <= trap_irq_i ? '0 : trap_tval_i;
            mstatus_q[7]     <= mstatus_q[3];
            mstatus_q[3]     <= 1'b0;
            mstatus_q[12:11] <= mode_q;
            mode_q           <= priv_m;
        end else if (mret_i) begin
            mstatus_q[3]     <= mstatus_q[7];
            mstatus_q[7]     <= 1'b1;
            mstatus_q[12:11] <= 2'b00;
            mode_q           <= priv_t'(mstatus_q[12:11]);
        end else if (wr_en) begin
            case (csr_idx_i)
                idx_mstatus:  mstatus_q  <= mstatus_wr;
                idx_mie:      mie_q      <= new_val & irq_mask;
                idx_mtvec:    mtvec_q    <= new_val & mtvec_mask;
                idx_mscratch: mscratch_q <= new_val;
                idx_mepc:     mepc_q     <= new_val & epc_mask;
                idx_mcause:   mcause_q   <= new_val & cause_mask;
                idx_mtval:    mtval_q    <= new_val;
                // misa and mip ignore writes
                default: ;
            endcase
        end
    end

    assign csr_rdata_o   = old_val;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;
    assign mie_o         = mie_q;
    assign mstatus_mie_o = mstatus_q[3];
    assign mode_o        = mode_q;

    // mret loads the mode from mpp, so mpp must stay legal too
    assert property (@(posedge clk) disable iff (rst) mode_q inside {priv_m, priv_u})
        else $error("csr_exec: illegal privilege mode");

endmodule

// ==== csr_irq.sv ====
`timescale 1ns/10ps

module csr_irq (
    input  logic            clk,
    input  logic            rst,
    input  logic            timer_irq_i,
    input  logic            soft_irq_i,
    input  logic            ext_irq_i,
    input  csr_pkg::xlen_t  mie_i,
    input  logic            mstatus_mie_i,
    input  csr_pkg::priv_t  mode_i,
    output csr_pkg::xlen_t  mip_o,
    output logic            irq_pending_o,
    output csr_pkg::cause_t irq_cause_o
);
    import csr_pkg::*;

    // bit order {ext, timer, soft}
    logic [2:0] sync_q1;
    logic [2:0] sync_q2;
    xlen_t      irq_en;
    logic       global_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= {ext_irq_i, timer_irq_i, soft_irq_i};
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        mip_o = '0;
        mip_o[irq_mei] = sync_q2[2];
        mip_o[irq_mti] = sync_q2[1];
        mip_o[irq_msi] = sync_q2[0];
    end

    // user mode is always interruptible by machine interrupts
    assign global_en = (mode_i == priv_u) || mstatus_mie_i;
    assign irq_en = mip_o & mie_i & {32{global_en}};

    always_comb begin
        if (irq_en[irq_mei]) begin
            irq_cause_o = irq_mei;
        end else if (irq_en[irq_msi]) begin
            irq_cause_o = irq_msi;
        end else if (irq_en[irq_mti]) begin
            irq_cause_o = irq_mti;
        end else begin
            irq_cause_o = '0;
        end
    end

    assign irq_pending_o = |irq_en;

    assert property (@(posedge clk) disable iff (rst) irq_pending_o |-> irq_cause_o != '0)
        else $error("csr_irq: pending interrupt without a cause");

endmodule

// ==== csr_result.sv ====
`timescale 1ns/10ps

module csr_result (
    input  logic            clk,
    input  logic            rst,
    input  logic            csr_en_i,
    input  logic            csr_illegal_i,
    input  csr_pkg::xlen_t  csr_rdata_i,
    input  logic            trap_i,
    input  logic            trap_irq_i,
    input  csr_pkg::cause_t trap_cause_i,
    input  logic            mret_i,
    input  csr_pkg::xlen_t  mtvec_i,
    input  csr_pkg::xlen_t  mepc_i,
    output logic            resp_valid_o,
    output csr_pkg::xlen_t  resp_rdata_o,
    output logic            resp_illegal_o,
    output logic            redirect_valid_o,
    output csr_pkg::xlen_t  redirect_pc_o
);
    import csr_pkg::*;

    xlen_t mtvec_base;
    xlen_t trap_target;

    assign mtvec_base = {mtvec_i[31:2], 2'b00};

    // vectored mode only applies to interrupts
    assign trap_target = (trap_irq_i && mtvec_i[0]) ?
                         mtvec_base + (xlen_t'(trap_cause_i) << 2) : mtvec_base;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_o     <= 1'b0;
            resp_illegal_o   <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            resp_valid_o     <= csr_en_i;
            resp_illegal_o   <= csr_illegal_i;
            redirect_valid_o <= trap_i | mret_i;
        end
    end

    // trap wins over mret
    always_ff @(posedge clk) begin
        resp_rdata_o  <= csr_illegal_i ? '0 : csr_rdata_i;
        redirect_pc_o <= trap_i ? trap_target : mepc_i;
    end

    assert property (@(posedge clk) disable iff (rst)
        redirect_valid_o |-> !$isunknown(redirect_pc_o))
        else $error("csr_result: redirect with unknown target");

endmodule

// ==== csr_unit.sv ====
`timescale 1ns/10ps

module csr_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_en_i,
    input  csr_pkg::csr_op_t   csr_op_i,
    input  logic               csr_imm_sel_i,
    input  logic [4:0]         csr_rs1_i,
    input  csr_pkg::csr_addr_t csr_addr_i,
    input  csr_pkg::xlen_t     csr_src_i,
    input  logic               trap_i,
    input  logic               trap_irq_i,
    input  csr_pkg::cause_t    trap_cause_i,
    input  csr_pkg::xlen_t     trap_pc_i,
    input  csr_pkg::xlen_t     trap_tval_i,
    input  logic               mret_i,
    input  logic               timer_irq_i,
    input  logic               soft_irq_i,
    input  logic               ext_irq_i,
    output logic               resp_valid_o,
    output csr_pkg::xlen_t     resp_rdata_o,
    output logic               resp_illegal_o,
    output logic               redirect_valid_o,
    output csr_pkg::xlen_t     redirect_pc_o,
    output logic               irq_pending_o,
    output csr_pkg::cause_t    irq_cause_o,
    output csr_pkg::priv_t     priv_mode_o
);
    import csr_pkg::*;

    csr_idx_t csr_idx;
    logic     csr_wr_en;
    logic     csr_illegal;
    xlen_t    csr_rdata;
    xlen_t    mtvec;
    xlen_t    mepc;
    xlen_t    mie;
    logic     mstatus_mie;
    priv_t    mode;
    xlen_t    mip;

    csr_decode csr_decode_i (
        .csr_en_i      (csr_en_i),
        .csr_op_i      (csr_op_i),
        .csr_rs1_i     (csr_rs1_i),
        .csr_addr_i    (csr_addr_i),
        .mode_i        (mode),
        .csr_idx_o     (csr_idx),
        .csr_wr_en_o   (csr_wr_en),
        .csr_illegal_o (csr_illegal)
    );

    csr_exec csr_exec_i (
        .clk           (clk),
        .rst           (rst),
        .csr_idx_i     (csr_idx),
        .csr_wr_en_i   (csr_wr_en),
        .csr_op_i      (csr_op_i),
        .csr_imm_sel_i (csr_imm_sel_i),
        .csr_rs1_i     (csr_rs1_i),
        .csr_src_i     (csr_src_i),
        .trap_i        (trap_i),
        .trap_irq_i    (trap_irq_i),
        .trap_cause_i  (trap_cause_i),
        .trap_pc_i     (trap_pc_i),
        .trap_tval_i   (trap_tval_i),
        .mret_i        (mret_i),
        .mip_i         (mip),
        .csr_rdata_o   (csr_rdata),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc),
        .mie_o         (mie),
        .mstatus_mie_o (mstatus_mie),
        .mode_o        (mode)
    );

    csr_irq csr_irq_i (
        .clk           (clk),
        .rst           (rst),
        .timer_irq_i   (timer_irq_i),
        .soft_irq_i    (soft_irq_i),
        .ext_irq_i     (ext_irq_i),
        .mie_i         (mie),
        .mstatus_mie_i (mstatus_mie),
        .mode_i        (mode),
        .mip_o         (mip),
        .irq_pending_o (irq_pending_o),
        .irq_cause_o   (irq_cause_o)
    );

    csr_result csr_result_i (
        .clk              (clk),
        .rst              (rst),
        .csr_en_i         (csr_en_i),
        .csr_illegal_i    (csr_illegal),
        .csr_rdata_i      (csr_rdata),
        .trap_i           (trap_i),
        .trap_irq_i       (trap_irq_i),
        .trap_cause_i     (trap_cause_i),
        .mret_i           (mret_i),
        .mtvec_i          (mtvec),
        .mepc_i           (mepc),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .resp_illegal_o   (resp_illegal_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    assign priv_mode_o = mode;

endmodule

// ==== tb_csr.sv ====
`timescale 1ns/10ps

module tb_csr;
    import csr_pkg::*;

    localparam int k_csr = 0;
    localparam int k_trap = 1;
    localparam int k_mret = 2;
    localparam int k_irq = 3;
    localparam int wait_limit = 20;

    logic       clk;
    logic       rst;
    logic       csr_en_i;
    csr_op_t    csr_op_i;
    logic       csr_imm_sel_i;
    logic [4:0] csr_rs1_i;
    csr_addr_t  csr_addr_i;
    xlen_t      csr_src_i;
    logic       trap_i;
    logic       trap_irq_i;
    cause_t     trap_cause_i;
    xlen_t      trap_pc_i;
    xlen_t      trap_tval_i;
    logic       mret_i;
    logic       timer_irq_i;
    logic       soft_irq_i;
    logic       ext_irq_i;
    logic       resp_valid_o;
    xlen_t      resp_rdata_o;
    logic       resp_illegal_o;
    logic       redirect_valid_o;
    xlen_t      redirect_pc_o;
    logic       irq_pending_o;
    cause_t     irq_cause_o;
    priv_t      priv_mode_o;

    // stimulus table with one entry per row in each queue
    int         t_kind[$];
    csr_op_t    t_op[$];
    logic       t_imm[$];
    csr_addr_t  t_addr[$];
    logic [4:0] t_rs1[$];
    xlen_t      t_data[$];
    logic       t_flag[$];
    logic       t_ill[$];
    priv_t      t_mode[$];

    // expected register state
    xlen_t m_mstatus;
    xlen_t m_mie;
    xlen_t m_mtvec;
    xlen_t m_mscratch;
    xlen_t m_mepc;
    xlen_t m_mcause;
    xlen_t m_mtval;
    priv_t m_mode;

    xlen_t rng;
    int    mismatches;
    int    timeouts;

    csr_unit csr_unit_i (
        .clk              (clk),
        .rst              (rst),
        .csr_en_i         (csr_en_i),
        .csr_op_i         (csr_op_i),
        .csr_imm_sel_i    (csr_imm_sel_i),
        .csr_rs1_i        (csr_rs1_i),
        .csr_addr_i       (csr_addr_i),
        .csr_src_i        (csr_src_i),
        .trap_i           (trap_i),
        .trap_irq_i       (trap_irq_i),
        .trap_cause_i     (trap_cause_i),
        .trap_pc_i        (trap_pc_i),
        .trap_tval_i      (trap_tval_i),
        .mret_i           (mret_i),
        .timer_irq_i      (timer_irq_i),
        .soft_irq_i       (soft_irq_i),
        .ext_irq_i        (ext_irq_i),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .resp_illegal_o   (resp_illegal_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .irq_pending_o    (irq_pending_o),
        .irq_cause_o      (irq_cause_o),
        .priv_mode_o      (priv_mode_o)
    );

    always #4 clk = ~clk;

    function automatic xlen_t xorshift(input xlen_t s);
        xlen_t x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic xlen_t model_read(input csr_addr_t a);
        case (a)
            addr_mstatus:   return m_mstatus;
            addr_mie:       return m_mie;
            addr_mtvec:     return m_mtvec;
            addr_mscratch:  return m_mscratch;
            addr_mepc:      return m_mepc;
            addr_mcause:    return m_mcause;
            addr_mtval:     return m_mtval;
            addr_mvendorid: return vendorid_value;
            default:        return 32'h0;
        endcase
    endfunction

    // mstatus keeps mie, mpie and a legal mpp
    function automatic void model_write(input csr_addr_t a, input xlen_t v);
        case (a)
            addr_mstatus:  m_mstatus = (v & 32'h0000_0088) |
                                       ((v[12:11] == 2'b11) ? 32'h0000_1800 : 32'h0);
            addr_mie:      m_mie = v & 32'h0000_0888;
            addr_mtvec:    m_mtvec = v & ~32'h0000_0002;
            addr_mscratch: m_mscratch = v;
            addr_mepc:     m_mepc = v & ~32'h0000_0003;
            addr_mcause:   m_mcause = v & 32'h8000_001f;
            addr_mtval:    m_mtval = v;
            default: ;
        endcase
    endfunction

    task automatic add_row(input int kind, input csr_op_t op, input logic imm,
                           input csr_addr_t addr, input logic [4:0] rs1, input xlen_t data,
                           input logic flag, input logic ill, input priv_t mode);
        t_kind.push_back(kind);
        t_op.push_back(op);
        t_imm.push_back(imm);
        t_addr.push_back(addr);
        t_rs1.push_back(rs1);
        t_data.push_back(data);
        t_flag.push_back(flag);
        t_ill.push_back(ill);
        t_mode.push_back(mode);
    endtask

    task automatic report_mismatch(input int r, input string what, input xlen_t got,
                                   input xlen_t exp);
        mismatches++;
        $display("mismatch at %0t ns: row %0d %s is %h, expected %h", $time, r, what, got, exp);
    endtask

    // sel 0 waits for the response, 1 for the redirect, 2 for the pending level
    task automatic wait_for(input int sel, input logic level, input int r, output logic seen);
        int   n;
        logic s;
        seen = 1'b0;
        n = 0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            case (sel)
                0:       s = resp_valid_o;
                1:       s = redirect_valid_o;
                default: s = irq_pending_o;
            endcase
            seen = (s == level);
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout at %0t ns: row %0d, the DUT output never reached the expected level",
                     $time, r);
        end
    endtask

    task automatic build_table();
        // kind, op, imm, addr, rs1 (trap cause, irq lines {ext, timer, soft}),
        // data (source, trap pc, irq cause), flag (random source, interrupt, pending),
        // illegal, mode
        add_row(k_csr, csr_op_rw, 1'b0, addr_mscratch, 5'd1, 32'h0, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mscratch, 5'd2, 32'h0, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rc, 1'b1, addr_mscratch, 5'h0f, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mscratch, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rw, 1'b0, addr_mtvec, 5'd3, 32'h0, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b1, addr_mtvec, 5'h02, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rc, 1'b0, addr_mtvec, 5'd4, 32'h0, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mtvec, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rw, 1'b1, addr_mepc, 5'h1f, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mepc, 5'd5, 32'h0, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rc, 1'b1, addr_mepc, 5'h10, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mepc, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rw, 1'b0, addr_mie, 5'd6, 32'h0, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b1, addr_mie, 5'h08, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rc, 1'b0, addr_mie, 5'd7, 32'h800, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mie, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        // illegal accesses
        add_row(k_csr, csr_op_rw, 1'b0, 12'h7c0, 5'd1, 32'h1234, 1'b0, 1'b1, priv_m);
        add_row(k_csr, csr_op_rw, 1'b0, addr_mhartid, 5'd1, 32'h5, 1'b0, 1'b1, priv_m);
        add_row(k_csr, csr_op_rs, 1'b1, addr_mvendorid, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        // exception entry with direct mtvec
        add_row(k_csr, csr_op_rw, 1'b0, addr_mtvec, 5'd1, 32'h1000_0100, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b1, addr_mstatus, 5'h08, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_trap, csr_op_rw, 1'b0, 12'h0, exc_illegal, 32'h8000_0042, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mepc, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mcause, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mtval, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mstatus, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        // mret into user mode, then back through a trap
        add_row(k_csr, csr_op_rc, 1'b0, addr_mstatus, 5'd1, 32'h1800, 1'b0, 1'b0, priv_m);
        add_row(k_mret, csr_op_rw, 1'b0, 12'h0, 5'd0, 32'h0, 1'b0, 1'b0, priv_u);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mscratch, 5'd0, 32'h0, 1'b0, 1'b1, priv_u);
        add_row(k_trap, csr_op_rw, 1'b0, 12'h0, exc_ecall_u, 32'h8000_0100, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mstatus, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mcause, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        // interrupt pending and priority
        add_row(k_csr, csr_op_rw, 1'b0, addr_mie, 5'd1, 32'h888, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b1, addr_mstatus, 5'h08, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_irq, csr_op_rw, 1'b0, 12'h0, 5'b00100, 32'd11, 1'b1, 1'b0, priv_m);
        add_row(k_irq, csr_op_rw, 1'b0, 12'h0, 5'b00101, 32'd11, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rc, 1'b1, addr_mstatus, 5'h08, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_irq, csr_op_rw, 1'b0, 12'h0, 5'b00101, 32'd0, 1'b0, 1'b0, priv_m);
        add_row(k_irq, csr_op_rw, 1'b0, 12'h0, 5'b00000, 32'd0, 1'b0, 1'b0, priv_m);
        // vectored mtvec
        add_row(k_csr, csr_op_rw, 1'b0, addr_mtvec, 5'd1, 32'h2000_0001, 1'b0, 1'b0, priv_m);
        add_row(k_trap, csr_op_rw, 1'b0, 12'h0, irq_mti, 32'h8000_0200, 1'b1, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mcause, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mtval, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
        add_row(k_trap, csr_op_rw, 1'b0, 12'h0, exc_illegal, 32'h8000_0204, 1'b0, 1'b0, priv_m);
        add_row(k_csr, csr_op_rs, 1'b0, addr_mcause, 5'd0, 32'h0, 1'b0, 1'b0, priv_m);
    endtask

    task automatic run_csr(input int r);
        xlen_t src;
        xlen_t old;
        xlen_t expected;
        xlen_t operand;
        xlen_t new_val;
        logic  seen;
        src = t_data[r];
        if (t_flag[r]) begin
            rng = xorshift(rng);
            src = rng;
        end
        old = model_read(t_addr[r]);
        expected = t_ill[r] ? 32'h0 : old;
        @(posedge clk);
        csr_en_i      <= 1'b1;
        csr_op_i      <= t_op[r];
        csr_imm_sel_i <= t_imm[r];
        csr_rs1_i     <= t_rs1[r];
        csr_addr_i    <= t_addr[r];
        csr_src_i     <= src;
        @(posedge clk);
        csr_en_i <= 1'b0;
        wait_for(0, 1'b1, r, seen);
        if (seen) begin
            assert (resp_illegal_o == t_ill[r])
                else report_mismatch(r, "illegal flag", xlen_t'(resp_illegal_o),
                                     xlen_t'(t_ill[r]));
            assert (resp_rdata_o == expected)
                else report_mismatch(r, "rdata", resp_rdata_o, expected);
            assert (priv_mode_o == t_mode[r])
                else report_mismatch(r, "mode", xlen_t'(priv_mode_o), xlen_t'(t_mode[r]));
        end
        operand = t_imm[r] ? {27'b0, t_rs1[r]} : src;
        case (t_op[r])
            csr_op_rs: new_val = old | operand;
            csr_op_rc: new_val = old & ~operand;
            default:   new_val = operand;
        endcase
        if (!t_ill[r] && (t_op[r] == csr_op_rw || t_rs1[r] != 5'd0)) begin
            model_write(t_addr[r], new_val);
        end
    endtask

    task automatic run_redirect(input int r);
        xlen_t tval;
        xlen_t base;
        xlen_t target;
        logic  seen;
        rng = xorshift(rng);
        tval = rng;
        base = m_mtvec & ~32'h3;
        if (t_kind[r] == k_mret) begin
            target = m_mepc;
        end else if (t_flag[r] && m_mtvec[0]) begin
            target = base + {25'b0, t_rs1[r], 2'b00};
        end else begin
            target = base;
        end
        @(posedge clk);
        trap_i       <= (t_kind[r] == k_trap);
        mret_i       <= (t_kind[r] == k_mret);
        trap_irq_i   <= t_flag[r];
        trap_cause_i <= t_rs1[r];
        trap_pc_i    <= t_data[r];
        trap_tval_i  <= tval;
        @(posedge clk);
        trap_i <= 1'b0;
        mret_i <= 1'b0;
        wait_for(1, 1'b1, r, seen);
        if (seen) begin
            assert (redirect_pc_o == target)
                else report_mismatch(r, "redirect pc", redirect_pc_o, target);
            assert (priv_mode_o == t_mode[r])
                else report_mismatch(r, "mode", xlen_t'(priv_mode_o), xlen_t'(t_mode[r]));
        end
        if (t_kind[r] == k_mret) begin
            m_mode = priv_t'(m_mstatus[12:11]);
            m_mstatus[3] = m_mstatus[7];
            m_mstatus[7] = 1'b1;
            m_mstatus[12:11] = 2'b00;
        end else begin
            m_mepc = t_data[r] & ~32'h3;
            m_mcause = {t_flag[r], 26'b0, t_rs1[r]};
            m_mtval = t_flag[r] ? 32'h0 : tval;
            m_mstatus[7] = m_mstatus[3];
            m_mstatus[3] = 1'b0;
            m_mstatus[12:11] = m_mode;
            m_mode = priv_m;
        end
    endtask

    task automatic run_irq(input int r);
        logic seen;
        @(posedge clk);
        ext_irq_i   <= t_rs1[r][2];
        timer_irq_i <= t_rs1[r][1];
        soft_irq_i  <= t_rs1[r][0];
        wait_for(2, t_flag[r], r, seen);
        // a line that leaves the pending level alone takes up to three edges
        repeat (3) @(negedge clk);
        if (seen) begin
            assert (irq_pending_o == t_flag[r])
                else report_mismatch(r, "irq pending", xlen_t'(irq_pending_o),
                                     xlen_t'(t_flag[r]));
            assert (irq_cause_o == t_data[r][4:0])
                else report_mismatch(r, "irq cause", xlen_t'(irq_cause_o), t_data[r]);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        csr_en_i = 1'b0;
        csr_op_i = csr_op_rw;
        csr_imm_sel_i = 1'b0;
        csr_rs1_i = 5'd0;
        csr_addr_i = 12'h0;
        csr_src_i = 32'h0;
        trap_i = 1'b0;
        trap_irq_i = 1'b0;
        trap_cause_i = 5'd0;
        trap_pc_i = 32'h0;
        trap_tval_i = 32'h0;
        mret_i = 1'b0;
        timer_irq_i = 1'b0;
        soft_irq_i = 1'b0;
        ext_irq_i = 1'b0;
        rng = 32'h57e0;
        mismatches = 0;
        timeouts = 0;
        m_mstatus = 32'h0;
        m_mie = 32'h0;
        m_mtvec = 32'h0;
        m_mscratch = 32'h0;
        m_mepc = 32'h0;
        m_mcause = 32'h0;
        m_mtval = 32'h0;
        m_mode = priv_m;
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!resp_valid_o && !redirect_valid_o && !irq_pending_o && priv_mode_o == priv_m)
            else begin
                mismatches++;
                $display("mismatch at %0t ns: outputs not in their reset state", $time);
            end
        for (int r = 0; r < t_kind.size(); r++) begin
            case (t_kind[r])
                k_csr:   run_csr(r);
                k_irq:   run_irq(r);
                default: run_redirect(r);
            endcase
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
csr_pkg.sv
csr_decode.sv
csr_exec.sv
csr_irq.sv
csr_result.sv
csr_unit.sv
tb_csr.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_csr
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJDIR)
